// File: design/rv_pkg.sv
// RV32I subset types; 32-bit words only, no byte or halfword access, no traps or CSRs
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    // Stall and flush vector width, index 0 is fetch
    localparam int stage_count = 5;

    // ADDI x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;
    localparam logic [31:0] ebreak_inst = 32'h0010_0073;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_idle,
        mem_wait,
        mem_done
    } mem_state_e;

    // All zero is a bubble
    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_we;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  is_jal;
        logic [xlen-1:0]       branch_target;
        logic                  is_halt;
    } id_ex_t;

    typedef struct packed {
        // ALU output, or the address of a load or store
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_we;
        logic                  is_load;
        logic                  is_store;
        logic                  is_halt;
    } ex_mem_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic                  reg_we;
        logic [xlen-1:0]       data;
        logic                  is_halt;
    } wb_t;

endpackage

`default_nettype wire

// File: design/hazard_ctrl.sv
// Stall and flush vectors; a memory wait stalls everything and any stall masks a flush
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl (
    input  logic                           load_use_i,
    input  logic                           mem_busy_i,
    input  logic                           redirect_i,
    output logic [rv_pkg::stage_count-1:0] stall_o,
    output logic [rv_pkg::stage_count-1:0] flush_o
);

    always_comb begin
        if (mem_busy_i) begin
            stall_o = 5'b11111;
        end else if (load_use_i) begin
            // Bubble lands in ID/EX
            stall_o = 5'b00111;
        end else begin
            stall_o = 5'b00000;
        end
        // Kill IF/ID and the decode result
        flush_o = redirect_i ? (5'b00110 & ~stall_o) : 5'b00000;
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
// 32 x 32 register file; x0 reads zero, a same-cycle write shows on the read ports
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          reset_i,
    input  rv_pkg::wb_t                   wb_i,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr_a_i,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr_b_i,
    output logic [rv_pkg::xlen-1:0]       rdata_a_o,
    output logic [rv_pkg::xlen-1:0]       rdata_b_o
);

    logic [rv_pkg::xlen-1:0] regs [32];
    logic                    wr_en;

    assign wr_en = wb_i.reg_we && (wb_i.rd != '0);

    // Registers start at zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                       (wr_en && wb_i.rd == raddr_a_i) ? wb_i.data : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       (wr_en && wb_i.rd == raddr_b_i) ? wb_i.data : regs[raddr_b_i];

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
// PC and IF/ID register; instruction memory must answer in the same cycle
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [rv_pkg::stage_count-1:0] stall_i,
    input  logic [rv_pkg::stage_count-1:0] flush_i,
    input  logic                           redirect_i,
    input  logic [rv_pkg::xlen-1:0]        redirect_pc_i,
    input  logic                           halt_i,
    output logic [rv_pkg::xlen-1:0]        imem_addr_o,
    input  logic [31:0]                    imem_data_i,
    output logic [rv_pkg::xlen-1:0]        id_pc_o,
    output logic [31:0]                    id_inst_o
);

    logic [rv_pkg::xlen-1:0] pc_q;

    assign imem_addr_o = pc_q;

    // PC freezes for good once halted
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= rv_pkg::reset_pc;
        end else if (!halt_i && !stall_i[0]) begin
            pc_q <= redirect_i ? redirect_pc_i : pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || (stall_i[1] && !stall_i[2])) begin
            id_pc_o   <= '0;
            id_inst_o <= rv_pkg::nop_inst;
        end else if (stall_i[1]) begin
            id_pc_o   <= id_pc_o;
            id_inst_o <= id_inst_o;
        end else if (flush_i[1]) begin
            // Wrong-path instruction
            id_pc_o   <= '0;
            id_inst_o <= rv_pkg::nop_inst;
        end else begin
            id_pc_o   <= pc_q;
            id_inst_o <= imem_data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
// Decoder and ID/EX register; unsupported opcodes decode as bubbles, BEQ is the only branch
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [rv_pkg::stage_count-1:0] stall_i,
    input  logic [rv_pkg::stage_count-1:0] flush_i,
    input  logic [rv_pkg::xlen-1:0]        id_pc_i,
    input  logic [31:0]                    id_inst_i,
    input  rv_pkg::wb_t                    ex_fwd_i,
    input  rv_pkg::wb_t                    mem_fwd_i,
    input  rv_pkg::wb_t                    wb_i,
    output logic                           load_use_o,
    output rv_pkg::id_ex_t                 id_ex_o
);

    logic [rv_pkg::reg_addr_w-1:0] rs1;
    logic [rv_pkg::reg_addr_w-1:0] rs2;
    logic [rv_pkg::xlen-1:0]       rf_a;
    logic [rv_pkg::xlen-1:0]       rf_b;
    logic [rv_pkg::xlen-1:0]       src_a;
    logic [rv_pkg::xlen-1:0]       src_b;
    logic [rv_pkg::xlen-1:0]       imm_i;
    logic [rv_pkg::xlen-1:0]       imm_s;
    logic [rv_pkg::xlen-1:0]       imm_b;
    logic [rv_pkg::xlen-1:0]       imm_u;
    logic [rv_pkg::xlen-1:0]       imm_j;
    logic                          use_rs1;
    logic                          use_rs2;
    rv_pkg::id_ex_t                id_ex_d;

    // Youngest producer wins, x0 never forwarded
    function automatic logic [rv_pkg::xlen-1:0] bypass(
        input logic [rv_pkg::reg_addr_w-1:0] addr,
        input logic [rv_pkg::xlen-1:0]       rf_val,
        input rv_pkg::wb_t                   ex,
        input rv_pkg::wb_t                   mem
    );
        if (addr == '0) return rf_val;
        if (ex.reg_we && ex.rd == addr) return ex.data;
        if (mem.reg_we && mem.rd == addr) return mem.data;
        return rf_val;
    endfunction

    assign rs1   = id_inst_i[19:15];
    assign rs2   = id_inst_i[24:20];
    assign imm_i = {{20{id_inst_i[31]}}, id_inst_i[31:20]};
    assign imm_s = {{20{id_inst_i[31]}}, id_inst_i[31:25], id_inst_i[11:7]};
    assign imm_b = {{20{id_inst_i[31]}}, id_inst_i[7], id_inst_i[30:25],
                    id_inst_i[11:8], 1'b0};
    assign imm_u = {id_inst_i[31:12], 12'b0};
    assign imm_j = {{12{id_inst_i[31]}}, id_inst_i[19:12], id_inst_i[20],
                    id_inst_i[30:21], 1'b0};
    assign src_a = bypass(rs1, rf_a, ex_fwd_i, mem_fwd_i);
    assign src_b = bypass(rs2, rf_b, ex_fwd_i, mem_fwd_i);

    reg_file u_reg_file (
        .clk       (clk),
        .reset_i   (reset_i),
        .wb_i      (wb_i),
        .raddr_a_i (rs1),
        .raddr_b_i (rs2),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b)
    );

    always_comb begin
        id_ex_d            = '0;
        id_ex_d.pc         = id_pc_i;
        id_ex_d.rd         = id_inst_i[11:7];
        id_ex_d.op_a       = src_a;
        id_ex_d.op_b       = src_b;
        id_ex_d.store_data = src_b;
        id_ex_d.alu_op     = rv_pkg::alu_add;
        use_rs1            = 1'b0;
        use_rs2            = 1'b0;
        case (rv_pkg::opcode_e'(id_inst_i[6:0]))
            rv_pkg::opc_op: begin
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                id_ex_d.reg_we = 1'b1;
                if (id_inst_i[14:12] == 3'b111) begin
                    id_ex_d.alu_op = rv_pkg::alu_and;
                end else if (id_inst_i[14:12] == 3'b110) begin
                    id_ex_d.alu_op = rv_pkg::alu_or;
                end else if (id_inst_i[30]) begin
                    id_ex_d.alu_op = rv_pkg::alu_sub;
                end
            end
            rv_pkg::opc_op_imm: begin
                use_rs1        = 1'b1;
                id_ex_d.reg_we = 1'b1;
                id_ex_d.op_b   = imm_i;
            end
            rv_pkg::opc_lui: begin
                id_ex_d.reg_we = 1'b1;
                id_ex_d.op_b   = imm_u;
                id_ex_d.alu_op = rv_pkg::alu_pass_b;
            end
            rv_pkg::opc_load: begin
                use_rs1         = 1'b1;
                id_ex_d.reg_we  = 1'b1;
                id_ex_d.is_load = 1'b1;
                id_ex_d.op_b    = imm_i;
            end
            rv_pkg::opc_store: begin
                use_rs1          = 1'b1;
                use_rs2          = 1'b1;
                id_ex_d.is_store = 1'b1;
                id_ex_d.op_b     = imm_s;
            end
            rv_pkg::opc_branch: begin
                use_rs1               = 1'b1;
                use_rs2               = 1'b1;
                id_ex_d.is_branch     = 1'b1;
                id_ex_d.branch_target = id_pc_i + imm_b;
            end
            rv_pkg::opc_jal: begin
                id_ex_d.reg_we        = 1'b1;
                id_ex_d.is_jal        = 1'b1;
                id_ex_d.branch_target = id_pc_i + imm_j;
            end
            rv_pkg::opc_system: begin
                id_ex_d.is_halt = (id_inst_i == rv_pkg::ebreak_inst);
            end
            default: begin
            end
        endcase
    end

    // Loaded value is not ready until the load leaves MEM
    assign load_use_o = id_ex_o.is_load && (id_ex_o.rd != '0) &&
                        ((use_rs1 && rs1 == id_ex_o.rd) || (use_rs2 && rs2 == id_ex_o.rd));

    always_ff @(posedge clk) begin
        if (reset_i || (stall_i[2] && !stall_i[3])) begin
            id_ex_o <= '0;
        end else if (stall_i[2]) begin
            id_ex_o <= id_ex_o;
        end else if (flush_i[2]) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
// ALU, BEQ and JAL resolution and EX/MEM register; branches resolve here, costing two bubbles
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [rv_pkg::stage_count-1:0] stall_i,
    input  rv_pkg::id_ex_t                 id_ex_i,
    output rv_pkg::wb_t                    ex_fwd_o,
    output logic                           redirect_o,
    output logic [rv_pkg::xlen-1:0]        redirect_pc_o,
    output rv_pkg::ex_mem_t                ex_mem_o
);

    logic [rv_pkg::xlen-1:0] alu_out;
    logic [rv_pkg::xlen-1:0] result;
    rv_pkg::ex_mem_t         ex_mem_d;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::alu_sub:    alu_out = id_ex_i.op_a - id_ex_i.op_b;
            rv_pkg::alu_and:    alu_out = id_ex_i.op_a & id_ex_i.op_b;
            rv_pkg::alu_or:     alu_out = id_ex_i.op_a | id_ex_i.op_b;
            rv_pkg::alu_pass_b: alu_out = id_ex_i.op_b;
            default:            alu_out = id_ex_i.op_a + id_ex_i.op_b;
        endcase
    end

    // JAL writes the link address
    assign result = id_ex_i.is_jal ? id_ex_i.pc + 32'd4 : alu_out;

    assign redirect_o = id_ex_i.is_jal ||
                        (id_ex_i.is_branch && id_ex_i.op_a == id_ex_i.op_b);
    assign redirect_pc_o = id_ex_i.branch_target;

    // Load data does not exist yet, so loads are not forwarded from here
    assign ex_fwd_o = '{rd: id_ex_i.rd,
                        reg_we: id_ex_i.reg_we && !id_ex_i.is_load,
                        data: result,
                        is_halt: id_ex_i.is_halt};

    assign ex_mem_d = '{result: result,
                        store_data: id_ex_i.store_data,
                        rd: id_ex_i.rd,
                        reg_we: id_ex_i.reg_we,
                        is_load: id_ex_i.is_load,
                        is_store: id_ex_i.is_store,
                        is_halt: id_ex_i.is_halt};

    always_ff @(posedge clk) begin
        if (reset_i || (stall_i[3] && !stall_i[4])) begin
            ex_mem_o <= '0;
        end else if (!stall_i[3]) begin
            ex_mem_o <= ex_mem_d;
        end
    end

endmodule

`default_nettype wire

// File: design/memory_stage.sv
// Data-memory FSM and MEM/WB register; one request per access, instructions after EBREAK are dropped
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [rv_pkg::stage_count-1:0] stall_i,
    input  rv_pkg::ex_mem_t                ex_mem_i,
    output logic                           dmem_re_o,
    output logic                           dmem_we_o,
    output logic [rv_pkg::xlen-1:0]        dmem_addr_o,
    output logic [rv_pkg::xlen-1:0]        dmem_wdata_o,
    input  logic [rv_pkg::xlen-1:0]        dmem_rdata_i,
    input  logic                           dmem_rvalid_i,
    input  logic                           dmem_wvalid_i,
    output logic                           mem_busy_o,
    output rv_pkg::wb_t                    mem_fwd_o,
    output rv_pkg::wb_t                    wb_o,
    output logic                           halt_o
);

    rv_pkg::mem_state_e      state_q;
    logic [rv_pkg::xlen-1:0] rdata_q;
    logic                    mem_op;
    logic                    complete;

    assign mem_op   = (ex_mem_i.is_load || ex_mem_i.is_store) && !halt_o;
    assign complete = (ex_mem_i.is_load && dmem_rvalid_i) ||
                      (ex_mem_i.is_store && dmem_wvalid_i);

    // Done gives the request one low cycle before the next access
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= rv_pkg::mem_idle;
        end else begin
            case (state_q)
                rv_pkg::mem_idle: if (mem_op) state_q <= rv_pkg::mem_wait;
                rv_pkg::mem_wait: if (complete) state_q <= rv_pkg::mem_done;
                default:          state_q <= rv_pkg::mem_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == rv_pkg::mem_wait && dmem_rvalid_i) begin
            rdata_q <= dmem_rdata_i;
        end
    end

    assign dmem_re_o    = (state_q == rv_pkg::mem_wait) && ex_mem_i.is_load;
    assign dmem_we_o    = (state_q == rv_pkg::mem_wait) && ex_mem_i.is_store;
    assign dmem_addr_o  = ex_mem_i.result;
    assign dmem_wdata_o = ex_mem_i.store_data;

    // Hold everything until the access has completed
    assign mem_busy_o = (state_q == rv_pkg::mem_idle && mem_op) ||
                        (state_q == rv_pkg::mem_wait);

    assign mem_fwd_o = '{rd: ex_mem_i.rd,
                         reg_we: ex_mem_i.reg_we && !halt_o,
                         data: ex_mem_i.is_load ? rdata_q : ex_mem_i.result,
                         is_halt: ex_mem_i.is_halt && !halt_o};

    // Nothing behind MEM/WB, so a stall here always leaves a bubble
    always_ff @(posedge clk) begin
        if (reset_i || stall_i[4]) begin
            wb_o <= '0;
        end else begin
            wb_o <= mem_fwd_o;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            halt_o <= 1'b0;
        end else if (!stall_i[4] && mem_fwd_o.is_halt) begin
            halt_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/pipe_top.sv
// Five-stage RV32I subset core; imem read is combinational, dmem completes by valid pulses
`timescale 1ns/1ns
`default_nettype none

module pipe_top (
    input  logic                    clk,
    input  logic                    reset_i,
    output logic [rv_pkg::xlen-1:0] imem_addr_o,
    input  logic [31:0]             imem_data_i,
    output logic                    dmem_re_o,
    output logic                    dmem_we_o,
    output logic [rv_pkg::xlen-1:0] dmem_addr_o,
    output logic [rv_pkg::xlen-1:0] dmem_wdata_o,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata_i,
    input  logic                    dmem_rvalid_i,
    input  logic                    dmem_wvalid_i,
    output logic                    halt_o
);

    logic [rv_pkg::stage_count-1:0] stall;
    logic [rv_pkg::stage_count-1:0] flush;
    logic                           load_use;
    logic                           mem_busy;
    logic                           redirect;
    logic [rv_pkg::xlen-1:0]        redirect_pc;
    logic [rv_pkg::xlen-1:0]        id_pc;
    logic [31:0]                    id_inst;
    rv_pkg::id_ex_t                 id_ex;
    rv_pkg::ex_mem_t                ex_mem;
    rv_pkg::wb_t                    ex_fwd;
    rv_pkg::wb_t                    mem_fwd;
    rv_pkg::wb_t                    wb;

    hazard_ctrl u_hazard_ctrl (
        .load_use_i (load_use),
        .mem_busy_i (mem_busy),
        .redirect_i (redirect),
        .stall_o    (stall),
        .flush_o    (flush)
    );

    fetch_stage u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall),
        .flush_i       (flush),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .halt_i        (halt_o),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .id_pc_o       (id_pc),
        .id_inst_o     (id_inst)
    );

    decode_stage u_decode (
        .clk        (clk),
        .reset_i    (reset_i),
        .stall_i    (stall),
        .flush_i    (flush),
        .id_pc_i    (id_pc),
        .id_inst_i  (id_inst),
        .ex_fwd_i   (ex_fwd),
        .mem_fwd_i  (mem_fwd),
        .wb_i       (wb),
        .load_use_o (load_use),
        .id_ex_o    (id_ex)
    );

    execute_stage u_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall),
        .id_ex_i       (id_ex),
        .ex_fwd_o      (ex_fwd),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_mem_o      (ex_mem)
    );

    memory_stage u_memory (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall),
        .ex_mem_i      (ex_mem),
        .dmem_re_o     (dmem_re_o),
        .dmem_we_o     (dmem_we_o),
        .dmem_addr_o   (dmem_addr_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .dmem_rdata_i  (dmem_rdata_i),
        .dmem_rvalid_i (dmem_rvalid_i),
        .dmem_wvalid_i (dmem_wvalid_i),
        .mem_busy_o    (mem_busy),
        .mem_fwd_o     (mem_fwd),
        .wb_o          (wb),
        .halt_o        (halt_o)
    );

endmodule

`default_nettype wire

// File: testbench/pipe_checker.sv
// Data-memory and halt protocol checks bound into pipe_top; expects one completion pulse per request
`timescale 1ns/1ns
`default_nettype none

module pipe_checker (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    dmem_re_o,
    input logic                    dmem_we_o,
    input logic [rv_pkg::xlen-1:0] dmem_addr_o,
    input logic [rv_pkg::xlen-1:0] dmem_wdata_o,
    input logic                    dmem_rvalid_i,
    input logic                    dmem_wvalid_i,
    input logic                    halt_o
);

    int failures = 0;

    // Read and write never overlap
    no_dual_request: assert property (@(posedge clk) disable iff (reset_i)
        !(dmem_re_o && dmem_we_o))
    else begin
        failures++;
        $error("dmem_re_o and dmem_we_o high in the same cycle");
    end

    read_held: assert property (@(posedge clk) disable iff (reset_i)
        dmem_re_o && !dmem_rvalid_i |=> dmem_re_o && $stable(dmem_addr_o))
    else begin
        failures++;
        $error("read request dropped or address changed before dmem_rvalid_i");
    end

    write_held: assert property (@(posedge clk) disable iff (reset_i)
        dmem_we_o && !dmem_wvalid_i |=>
            dmem_we_o && $stable(dmem_addr_o) && $stable(dmem_wdata_o))
    else begin
        failures++;
        $error("write request dropped or address or data changed before dmem_wvalid_i");
    end

    // Request goes low right after its completion pulse
    request_drops: assert property (@(posedge clk) disable iff (reset_i)
        (dmem_re_o && dmem_rvalid_i) || (dmem_we_o && dmem_wvalid_i) |=>
            !dmem_re_o && !dmem_we_o)
    else begin
        failures++;
        $error("request still high in the cycle after its completion pulse");
    end

    halt_sticky: assert property (@(posedge clk) disable iff (reset_i)
        halt_o |=> halt_o)
    else begin
        failures++;
        $error("halt_o fell without a reset");
    end

endmodule

bind pipe_top pipe_checker u_checker (.*);

`default_nettype wire

// File: testbench/pipe_tb.sv
// Fixed 24-word program; data memory covers 1 KiB of word addresses and answers after 1 to 4 cycles
`timescale 1ns/1ns
`default_nettype none

module pipe_tb;

    localparam int prog_len = 24;
    localparam int mem_instr = 10;
    localparam int max_latency = 4;
    localparam int reset_cycles = 16;
    localparam int drain_cycles = 20;
    localparam int timeout_cycles = reset_cycles + drain_cycles + prog_len * 40 +
                                    mem_instr * max_latency;
    localparam logic [6:0] opc_imm = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_sys = 7'b1110011;

    logic        clk = 1'b0;
    logic        reset_i = 1'b1;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        dmem_re;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata = '0;
    logic        dmem_rvalid = 1'b0;
    logic        dmem_wvalid = 1'b0;
    logic        halt;

    logic [31:0] rom [32];
    logic [31:0] dmem [256];
    logic [31:0] store_addr_q [$];
    logic [31:0] store_data_q [$];
    integer      seed = 19901;
    int          wait_left = 0;
    int          request_count = 0;
    int          late_requests = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_fails = 0;
    string       test_name;

    pipe_top UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .imem_addr_o   (imem_addr),
        .imem_data_i   (imem_data),
        .dmem_re_o     (dmem_re),
        .dmem_we_o     (dmem_we),
        .dmem_addr_o   (dmem_addr),
        .dmem_wdata_o  (dmem_wdata),
        .dmem_rdata_i  (dmem_rdata),
        .dmem_rvalid_i (dmem_rvalid),
        .dmem_wvalid_i (dmem_wvalid),
        .halt_o        (halt)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // Instruction fetch answers in the same cycle
    assign imem_data = rom[imem_addr[6:2]];

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // SW only
    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // BEQ only
    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ 32'h5A5A_5A5A;
    endfunction

    function automatic int find_store(input logic [31:0] addr);
        foreach (store_addr_q[i]) begin
            if (store_addr_q[i] == addr) return i;
        end
        return -1;
    endfunction

    task automatic load_program();
        for (int i = 0; i < 32; i++) begin
            rom[i] = itype(12'd0, 5'd0, 3'b000, 5'd0, opc_imm);
        end
        rom[0]  = itype(12'd100, 5'd0, 3'b000, 5'd1, opc_imm);
        rom[1]  = itype(12'hFF9, 5'd1, 3'b000, 5'd2, opc_imm);
        rom[2]  = rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        rom[3]  = rtype(7'h20, 5'd3, 5'd2, 3'b000, 5'd4);
        rom[4]  = utype(20'h12345, 5'd5);
        rom[5]  = itype(12'h678, 5'd5, 3'b000, 5'd5, opc_imm);
        rom[6]  = rtype(7'h00, 5'd4, 5'd5, 3'b111, 5'd6);
        rom[7]  = rtype(7'h00, 5'd3, 5'd6, 3'b110, 5'd7);
        rom[8]  = stype(12'h100, 5'd7, 5'd0);
        rom[9]  = stype(12'h104, 5'd4, 5'd0);
        // Load followed at once by its consumer
        rom[10] = itype(12'h200, 5'd0, 3'b010, 5'd8, opc_load);
        rom[11] = rtype(7'h00, 5'd1, 5'd8, 3'b000, 5'd9);
        rom[12] = stype(12'h108, 5'd9, 5'd0);
        rom[13] = itype(12'd5, 5'd0, 3'b000, 5'd10, opc_imm);
        rom[14] = itype(12'd5, 5'd0, 3'b000, 5'd11, opc_imm);
        rom[15] = btype(13'd12, 5'd11, 5'd10);
        rom[16] = stype(12'h180, 5'd1, 5'd0);
        rom[17] = stype(12'h184, 5'd2, 5'd0);
        rom[18] = stype(12'h10C, 5'd10, 5'd0);
        rom[19] = jtype(21'd8, 5'd12);
        rom[20] = stype(12'h188, 5'd1, 5'd0);
        rom[21] = stype(12'h110, 5'd12, 5'd0);
        // EBREAK, then a store that must never reach memory
        rom[22] = itype(12'h001, 5'd0, 3'b000, 5'd0, opc_sys);
        rom[23] = stype(12'h18C, 5'd1, 5'd0);
    endtask

    task automatic complete_request();
        if (dmem_re) begin
            dmem_rdata  <= dmem[dmem_addr[9:2]];
            dmem_rvalid <= 1'b1;
        end else begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            dmem_wvalid <= 1'b1;
            store_addr_q.push_back(dmem_addr);
            store_data_q.push_back(dmem_wdata);
        end
    endtask

    // Each new request gets a random latency of 1 to 4 cycles
    always @(posedge clk) begin : dmem_model
        int delay;
        dmem_rvalid <= 1'b0;
        dmem_wvalid <= 1'b0;
        if (halt && (dmem_re || dmem_we)) begin
            late_requests <= late_requests + 1;
        end
        if (reset_i) begin
            wait_left <= 0;
        end else if (wait_left != 0) begin
            wait_left <= wait_left - 1;
            if (wait_left == 1) begin
                complete_request();
            end
        end else if ((dmem_re || dmem_we) && !dmem_rvalid && !dmem_wvalid) begin
            request_count <= request_count + 1;
            delay = 1 + ($unsigned($random(seed)) % max_latency);
            if (delay == 1) begin
                complete_request();
            end else begin
                wait_left <= delay - 1;
            end
        end
    end

    task automatic start_test(input string name);
        test_name = name;
        test_fails = 0;
    endtask

    task automatic finish_test();
        $display("test %s: %s", test_name, (test_fails == 0) ? "pass" : "fail");
    endtask

    task automatic compare_word(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            test_fails++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, expected,
                     actual);
        end
    endtask

    task automatic require(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            test_fails++;
            $display("%s: %s", test_name, msg);
        end
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] expected);
        int idx;
        idx = find_store(addr);
        require(idx >= 0, $sformatf("no store reached address %h", addr));
        if (idx >= 0) begin
            compare_word($sformatf("word at %h", addr), expected, store_data_q[idx]);
        end
    endtask

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: halt_o did not rise within %0d cycles", timeout_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin : main
        logic [31:0] e1;
        logic [31:0] e2;
        logic [31:0] e3;
        logic [31:0] e4;
        logic [31:0] e5;
        logic [31:0] e6;
        logic [31:0] e7;
        logic [31:0] e9;
        logic [31:0] link;
        logic [31:0] exp_addr [$];
        logic [31:0] exp_data [$];
        int          n;
        load_program();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(32'(i) * 4);
        end
        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        start_test("reset_state");
        compare_word("imem_addr_o", rv_pkg::reset_pc, imem_addr);
        require(!dmem_re && !dmem_we, "memory request active during reset");
        require(!halt, "halt_o high during reset");
        finish_test();
        @(posedge clk);
        reset_i <= 1'b0;

        while (!halt) begin
            @(negedge clk);
        end
        // Let anything that might follow EBREAK show up
        repeat (drain_cycles) @(negedge clk);

        e1 = 32'd100;
        e2 = e1 - 32'd7;
        e3 = e1 + e2;
        e4 = e2 - e3;
        e5 = (32'h12345 << 12) + 32'h678;
        e6 = e5 & e4;
        e7 = e6 | e3;
        e9 = fill_word(32'h200) + e1;
        link = 32'd19 * 4 + 32'd4;

        start_test("arith_forward");
        check_store(32'h100, e7);
        check_store(32'h104, e4);
        finish_test();

        start_test("load_use");
        check_store(32'h108, e9);
        finish_test();

        start_test("branch_flush");
        require(find_store(32'h180) < 0, "first store after the taken BEQ was performed");
        require(find_store(32'h184) < 0, "second store after the taken BEQ was performed");
        check_store(32'h10C, 32'd5);
        finish_test();

        start_test("jal_link");
        check_store(32'h110, link);
        require(find_store(32'h188) < 0, "store skipped by JAL was performed");
        finish_test();

        start_test("mem_latency");
        exp_addr = '{32'h100, 32'h104, 32'h108, 32'h10C, 32'h110};
        exp_data = '{e7, e4, e9, 32'd5, link};
        compare_word("store count", exp_addr.size(), store_addr_q.size());
        n = (store_addr_q.size() < exp_addr.size()) ? store_addr_q.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            compare_word($sformatf("store %0d address", i), exp_addr[i], store_addr_q[i]);
            compare_word($sformatf("store %0d data", i), exp_data[i], store_data_q[i]);
        end
        compare_word("protocol assertion failures", 32'd0, UUT.u_checker.failures);
        finish_test();

        start_test("halt");
        require(halt, "halt_o did not stay high after EBREAK");
        compare_word("requests after halt", 32'd0, late_requests);
        compare_word("memory requests issued", 32'd6, request_count);
        require(find_store(32'h18C) < 0, "store after EBREAK was performed");
        finish_test();

        $display("Tests done: %0d checks, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
design/rv_pkg.sv
design/hazard_ctrl.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/pipe_top.sv
testbench/pipe_checker.sv
testbench/pipe_tb.sv
